// File: include/ula_settings.svh
// Word, float field and opcode widths of the ULA
// Included by the package and by every RTL file that sizes a vector

`ifndef ULA_SETTINGS_SVH
`define ULA_SETTINGS_SVH

// Integer word
`define ULA_NUBITS 32

// Float fields of one word
`define ULA_NBMANT 23  // Magnitude mantissa, no hidden bit
`define ULA_NBEXPO 8   // Two's complement exponent

// Opcode
`define ULA_NBOPCO 6

// Exponent of float zero, -128
`define ULA_EXPZERO {1'b1, {(`ULA_NBEXPO-1){1'b0}}}

`endif

// File: source/ula_pkg.sv
// Shared types of the ULA datapath
// Opcode enum with the accumulator machine numbering, word and float field types

`default_nettype none

`include "ula_settings.svh"

package ula_pkg;

	// ************************************************************
	// Opcodes
	// ************************************************************

	typedef enum logic [`ULA_NBOPCO-1:0] {
		NOP   = 6'd0,   // Pass accumulator
		LOD   = 6'd1,   // Pass memory operand
		ADD   = 6'd2,
		F_ADD = 6'd3,
		MLT   = 6'd4,
		F_MLT = 6'd5,
		DIV   = 6'd6,
		MOD   = 6'd8,
		SGN   = 6'd9,   // Sign of in1 onto in2
		F_SGN = 6'd10,
		NEG   = 6'd11,
		F_NEG = 6'd13,
		ABS   = 6'd15,
		F_ABS = 6'd17,
		PST   = 6'd19,  // Zero if negative
		F_PST = 6'd21,
		AND   = 6'd29,
		ORR   = 6'd30,
		XOR   = 6'd31,
		INV   = 6'd32,
		LAN   = 6'd34,  // Logical and
		LOR   = 6'd35,  // Logical or
		LIN   = 6'd36,  // Logical not
		LES   = 6'd38,
		F_LES = 6'd39,
		GRE   = 6'd40,
		F_GRE = 6'd41,
		EQU   = 6'd42,
		SHL   = 6'd43,
		SHR   = 6'd44,
		SRS   = 6'd45   // Arithmetic right shift
	} ula_op_t;

	// ************************************************************
	// Data types
	// ************************************************************

	typedef logic signed [`ULA_NUBITS-1:0] ula_word_t;  // Operand or result
	typedef logic signed [`ULA_NBEXPO-1:0] ula_exp_t;   // Float exponent
	typedef logic signed [`ULA_NBMANT:0]   ula_sman_t;  // Mantissa with sign after alignment

endpackage

`default_nettype wire

// File: source/ula_unit_if.sv
// Link between the result selector and one execution unit
// The selector drives opcode and operands, the unit answers with its result

`timescale 1ns/10ps
`default_nettype none

interface ula_unit_if;
	import ula_pkg::*;

	ula_op_t   op;      // Decoded opcode
	ula_word_t in1;     // Memory operand
	ula_word_t in2;     // Accumulator operand
	ula_word_t result;  // Combinational unit result

	// Execution unit side
	modport unit (input op, in1, in2, output result);

	// Selector side
	modport sel (output op, in1, in2, input result);

endinterface

`default_nettype wire

// File: source/ula_norm.sv
// Leading-zero normalizer for float sums and products
// Moves the mantissa up until its top bit is set and lowers the exponent to match

`timescale 1ns/10ps
`default_nettype none

`include "ula_settings.svh"

module ula_norm (
	input  ula_pkg::ula_word_t raw,   // Float before normalization
	output ula_pkg::ula_word_t norm   // Same value, mantissa top bit set
);
	import ula_pkg::*;

	logic                   sgn;
	ula_exp_t               exp_in, exp_out;
	logic [`ULA_NBMANT-1:0] man;
	ula_exp_t               lz;       // Leading zero count

	assign sgn    = raw[`ULA_NUBITS-1];
	assign exp_in = raw[`ULA_NUBITS-2:`ULA_NBMANT];
	assign man    = raw[`ULA_NBMANT-1:0];

	// Priority chain, the highest set bit wins
	always_comb begin
		lz = '0;
		for (int i = 0; i < `ULA_NBMANT; i++) begin
			if (man[i])
				lz = ula_exp_t'(`ULA_NBMANT - 1 - i);
		end
	end

	// Zero mantissa gets the zero exponent
	assign exp_out = (man == '0) ? `ULA_EXPZERO : exp_in - lz;

	assign norm = {sgn, exp_out, man << lz};

endmodule

`default_nettype wire

// File: source/ula_int_arith.sv
// Integer arithmetic unit of the ULA
// Combinational ADD, MLT, DIV, MOD, SGN, NEG, ABS and PST on signed words

`timescale 1ns/10ps
`default_nettype none

`include "ula_settings.svh"

module ula_int_arith (
	ula_unit_if.unit bus  // Opcode and operands in, result out
);
	import ula_pkg::*;

	ula_word_t a, b;       // Memory and accumulator operands
	logic      div_zero;   // Divisor is zero
	ula_word_t dvs;        // Divisor kept nonzero
	ula_word_t quo, rem;
	ula_word_t neg_b;
	logic      same_sign;

	assign a = bus.in1;
	assign b = bus.in2;

	// ************************************************************
	// Division
	// ************************************************************

	assign div_zero = (b == '0);
	assign dvs      = div_zero ? ula_word_t'(1) : b;  // Avoid x from a zero divisor
	assign quo      = a / dvs;                         // Signed, rounds toward zero
	assign rem      = a % dvs;                         // Sign follows a

	// ************************************************************
	// Sign handling
	// ************************************************************

	assign neg_b     = -b;
	assign same_sign = (a[`ULA_NUBITS-1] == b[`ULA_NUBITS-1]);

	// Operation select
	always_comb begin
		case (bus.op)
			MLT: bus.result = a * b;                           // Low word of product
			DIV: bus.result = div_zero ? '0 : quo;
			MOD: bus.result = div_zero ? '0 : rem;
			SGN: bus.result = same_sign ? b : neg_b;
			NEG: bus.result = neg_b;
			ABS: bus.result = b[`ULA_NUBITS-1] ? neg_b : b;
			PST: bus.result = b[`ULA_NUBITS-1] ? '0 : b;       // Clamp negatives
			default: bus.result = a + b;                       // ADD
		endcase
	end

endmodule

`default_nettype wire

// File: source/ula_logic.sv
// Bitwise, conditional, compare and shift unit of the ULA
// Conditionals and compares answer 1 or 0 in a full word

`timescale 1ns/10ps
`default_nettype none

`include "ula_settings.svh"

module ula_logic (
	ula_unit_if.unit bus  // Opcode and operands in, result out
);
	import ula_pkg::*;

	ula_word_t              a, b;       // Memory and accumulator operands
	logic                   a_nz, b_nz; // Operand is nonzero
	logic                   flag;       // One-bit answer of a test
	logic [`ULA_NUBITS-1:0] sh;         // Shift count, unsigned

	assign a    = bus.in1;
	assign b    = bus.in2;
	assign a_nz = (a != '0);
	assign b_nz = (b != '0);
	assign sh   = b;

	// ************************************************************
	// Conditionals and compares
	// ************************************************************

	always_comb begin
		case (bus.op)
			LAN:     flag = a_nz && b_nz;
			LOR:     flag = a_nz || b_nz;
			LIN:     flag = !b_nz;       // Only in2 counts
			LES:     flag = (a < b);     // Signed
			GRE:     flag = (a > b);
			default: flag = (a == b);    // EQU
		endcase
	end

	// ************************************************************
	// Result select
	// ************************************************************

	always_comb begin
		case (bus.op)
			AND: bus.result = a & b;
			ORR: bus.result = a | b;
			XOR: bus.result = a ^ b;
			INV: bus.result = ~b;                  // Accumulator only
			SHL: bus.result = a << sh;
			SHR: bus.result = a >> sh;             // Fills with zeros
			SRS: bus.result = a >>> sh;            // Keeps the sign
			default: bus.result = {{(`ULA_NUBITS-1){1'b0}}, flag};
		endcase
	end

endmodule

`default_nettype wire

// File: source/ula_float.sv
// Float unit of the ULA
// Word is sign, 8-bit two's complement exponent, 23-bit mantissa without hidden bit
// Sums and products leave through the normalizer, sign ops and compares do not

`timescale 1ns/10ps
`default_nettype none

`include "ula_settings.svh"

module ula_float (
	ula_unit_if.unit bus  // Opcode and operands in, result out
);
	import ula_pkg::*;

	// Unpacked operands
	logic                     s1, s2;
	ula_exp_t                 e1, e2;
	logic [`ULA_NBMANT-1:0]   m1, m2;
	// Alignment
	logic signed [`ULA_NBEXPO:0] e_diff;  // e1 - e2, one bit wider
	logic                     e2_big;
	logic [`ULA_NBEXPO:0]     sh1, sh2;
	ula_exp_t                 e_big;
	logic [`ULA_NBMANT-1:0]   am1, am2;
	ula_sman_t                sm1, sm2;
	// Add and multiply
	logic signed [`ULA_NBMANT+1:0] sum, sum_mag;
	ula_exp_t                 e_add, e_mlt;
	logic [2*`ULA_NBMANT-1:0] prod;
	logic [`ULA_NBMANT-1:0]   m_mlt;
	ula_word_t                fadd_raw, fmlt_raw, norm_in, norm_res;
	ula_word_t                fzero;
	logic                     flag;

	assign s1 = bus.in1[`ULA_NUBITS-1];
	assign s2 = bus.in2[`ULA_NUBITS-1];
	assign e1 = bus.in1[`ULA_NUBITS-2:`ULA_NBMANT];
	assign e2 = bus.in2[`ULA_NUBITS-2:`ULA_NBMANT];
	assign m1 = bus.in1[`ULA_NBMANT-1:0];
	assign m2 = bus.in2[`ULA_NBMANT-1:0];

	assign fzero = {1'b0, `ULA_EXPZERO, {`ULA_NBMANT{1'b0}}};

	// ************************************************************
	// Alignment to the larger exponent
	// ************************************************************

	assign e_diff = e1 - e2;
	assign e2_big = e_diff[`ULA_NBEXPO];          // Negative difference
	assign sh1    = e2_big ? -e_diff : '0;
	assign sh2    = e2_big ? '0 : e_diff;
	assign e_big  = e2_big ? e2 : e1;

	assign am1 = m1 >> sh1;                       // Only the smaller one moves
	assign am2 = m2 >> sh2;
	assign sm1 = s1 ? -ula_sman_t'({1'b0, am1}) : ula_sman_t'({1'b0, am1});
	assign sm2 = s2 ? -ula_sman_t'({1'b0, am2}) : ula_sman_t'({1'b0, am2});

	// ************************************************************
	// F_ADD and F_MLT
	// ************************************************************

	assign sum      = sm1 + sm2;                  // Extra bit for carry
	assign sum_mag  = sum[`ULA_NBMANT+1] ? -sum : sum;
	assign e_add    = e_big + ula_exp_t'(1);      // Makes up for the dropped bit
	assign fadd_raw = {sum[`ULA_NBMANT+1], e_add, sum_mag[`ULA_NBMANT:1]};

	assign prod     = m1 * m2;
	assign m_mlt    = prod[2*`ULA_NBMANT-1:`ULA_NBMANT];  // Upper half
	assign e_mlt    = e1 + e2 + ula_exp_t'(`ULA_NBMANT);
	assign fmlt_raw = (m_mlt == '0) ? fzero : {s1 ^ s2, e_mlt, m_mlt};

	assign norm_in = (bus.op == F_MLT) ? fmlt_raw : fadd_raw;

	ula_norm i_norm (
		.raw  (norm_in),
		.norm (norm_res)
	);

	// ************************************************************
	// Sign ops and compares
	// ************************************************************

	assign flag = (bus.op == F_LES) ? (sm1 < sm2) : (sm1 > sm2);  // F_GRE otherwise

	always_comb begin
		case (bus.op)
			F_SGN: bus.result = {s1, bus.in2[`ULA_NUBITS-2:0]};
			F_NEG: bus.result = {~s2, bus.in2[`ULA_NUBITS-2:0]};
			F_ABS: bus.result = {1'b0, bus.in2[`ULA_NUBITS-2:0]};
			F_PST: bus.result = s2 ? fzero : bus.in2;
			F_LES, F_GRE: bus.result = {{(`ULA_NUBITS-1){1'b0}}, flag};
			default: bus.result = norm_res;        // F_ADD and F_MLT
		endcase
	end

endmodule

`default_nettype wire

// File: source/ula_mux.sv
// Result selector and output register of the ULA
// Fans the opcode and operands out to the three units and registers the chosen result

`timescale 1ns/10ps
`default_nettype none

`include "ula_settings.svh"

module ula_mux (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [`ULA_NBOPCO-1:0] op,         // Raw opcode
	input  ula_pkg::ula_word_t     in1,        // Memory operand
	input  ula_pkg::ula_word_t     in2,        // Accumulator operand
	ula_unit_if.sel                int_bus,
	ula_unit_if.sel                logic_bus,
	ula_unit_if.sel                float_bus,
	output ula_pkg::ula_word_t     out         // Registered result
);
	import ula_pkg::*;

	ula_op_t   op_e;   // Decoded opcode
	ula_word_t res;    // Next output value

	assign op_e = ula_op_t'(op);

	// Same opcode and operands to every unit
	assign int_bus.op    = op_e;
	assign int_bus.in1   = in1;
	assign int_bus.in2   = in2;
	assign logic_bus.op  = op_e;
	assign logic_bus.in1 = in1;
	assign logic_bus.in2 = in2;
	assign float_bus.op  = op_e;
	assign float_bus.in1 = in1;
	assign float_bus.in2 = in2;

	// ************************************************************
	// Group select
	// ************************************************************

	always_comb begin
		case (op_e)
			NOP: res = in2;
			LOD: res = in1;
			ADD, MLT, DIV, MOD, SGN, NEG, ABS, PST:
				res = int_bus.result;
			AND, ORR, XOR, INV, LAN, LOR, LIN, LES, GRE, EQU, SHL, SHR, SRS:
				res = logic_bus.result;
			F_ADD, F_MLT, F_SGN, F_NEG, F_ABS, F_PST, F_LES, F_GRE:
				res = float_bus.result;
			default: res = '0;   // Unused opcodes
		endcase
	end

	// One cycle of latency
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			out <= '0;
		else
			out <= res;
	end

endmodule

`default_nettype wire

// File: source/ula.sv
// Top level of the registered ULA for the accumulator machine
// Opcode and operands sampled at each rising clk edge, result on out one cycle later

`timescale 1ns/10ps
`default_nettype none

`include "ula_settings.svh"

module ula (
	input  logic                   clk,
	input  logic                   arst_n,   // Asynchronous, active low
	input  logic [`ULA_NBOPCO-1:0] op,
	input  ula_pkg::ula_word_t     in1,      // From memory
	input  ula_pkg::ula_word_t     in2,      // From accumulator
	output ula_pkg::ula_word_t     out
);

	// One link per execution unit
	ula_unit_if int_bus ();
	ula_unit_if logic_bus ();
	ula_unit_if float_bus ();

	ula_mux i_mux (
		.clk       (clk),
		.arst_n    (arst_n),
		.op        (op),
		.in1       (in1),
		.in2       (in2),
		.int_bus   (int_bus),
		.logic_bus (logic_bus),
		.float_bus (float_bus),
		.out       (out)
	);

	ula_int_arith i_int_arith (.bus (int_bus));
	ula_logic     i_logic     (.bus (logic_bus));
	ula_float     i_float     (.bus (float_bus));

endmodule

`default_nettype wire

// File: verif/ula_asserts.sv
// Concurrent checks on the ULA output, bound to the top level
// Reset value, known output after reset, bitwise results one cycle later

`timescale 1ns/10ps
`default_nettype none

`include "ula_settings.svh"

module ula_asserts (
	input logic                   clk,
	input logic                   arst_n,
	input logic [`ULA_NBOPCO-1:0] op,
	input ula_pkg::ula_word_t     in1,
	input ula_pkg::ula_word_t     in2,
	input ula_pkg::ula_word_t     out
);
	import ula_pkg::*;

	// ************************************************************
	// Reset and known output
	// ************************************************************

	reset_zero: assert property (@(posedge clk) !arst_n |-> (out == '0))
		else $error("out not zero while arst_n is low");

	out_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(out))
		else $error("out has unknown bits after reset");

	// ************************************************************
	// Bitwise ops, one cycle of latency
	// ************************************************************

	and_result: assert property (@(posedge clk) disable iff (!arst_n)
		(op == AND) |=> (out == $past(in1 & in2)))
		else $error("AND result wrong");

	orr_result: assert property (@(posedge clk) disable iff (!arst_n)
		(op == ORR) |=> (out == $past(in1 | in2)))
		else $error("ORR result wrong");

	xor_result: assert property (@(posedge clk) disable iff (!arst_n)
		(op == XOR) |=> (out == $past(in1 ^ in2)))  // Previous operands
		else $error("XOR result wrong");

endmodule

bind ula ula_asserts i_asserts (
	.clk    (clk),
	.arst_n (arst_n),
	.op     (op),
	.in1    (in1),
	.in2    (in2),
	.out    (out)
);

`default_nettype wire

// File: verif/ula_tb.sv
// Directed testbench for the registered ULA
// One vector per cycle, each result checked one edge later against the opcode rules

`timescale 1ns/10ps
`default_nettype none

`include "ula_settings.svh"

module ula_tb;
	import ula_pkg::*;

	localparam int PERIOD       = 100;  // ns
	localparam int RESET_CYCLES = 8;
	localparam int RAND_ROUNDS  = 6;    // Random passes over an op list
	localparam int N_INT_OPS    = 10;
	localparam int N_LOGIC_OPS  = 13;
	localparam int N_B2B        = 16;
	localparam int N_VEC        = 2 + (12 + N_INT_OPS * RAND_ROUNDS)
		+ (19 + N_LOGIC_OPS * RAND_ROUNDS) + 8 + 12 + N_B2B;
	localparam logic [31:0] SEED = 32'hd346_f7ae;

	logic                   clk;
	logic                   arst_n;
	logic [`ULA_NBOPCO-1:0] op;
	ula_word_t              in1, in2, out;

	ula_op_t int_ops [N_INT_OPS]     = '{NOP, LOD, ADD, MLT, DIV, MOD, SGN, NEG, ABS, PST};
	ula_op_t logic_ops [N_LOGIC_OPS] = '{AND, ORR, XOR, INV, LAN, LOR, LIN, LES, GRE, EQU,
		SHL, SHR, SRS};
	ula_op_t b2b_ops [N_B2B] = '{ADD, XOR, F_MLT, SHL, NEG, F_ADD, EQU, LOD, MOD, F_GRE,
		INV, SRS, F_NEG, SGN, LOR, NOP};  // Groups change every cycle
	ula_op_t cond_ops [3]  = '{LAN, LOR, LIN};
	ula_op_t shift_ops [3] = '{SHL, SHR, SRS};
	ula_op_t sign_ops [4]  = '{F_SGN, F_NEG, F_ABS, F_PST};
	int      shift_counts [3] = '{0, 5, 31};

	ula i_ula (.clk (clk), .arst_n (arst_n), .op (op), .in1 (in1), .in2 (in2), .out (out));

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Two periods per vector is far more than one cycle of latency needs
	initial begin
		#((N_VEC * 2 + RESET_CYCLES + 2) * PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$fatal(1, "Timeout");
	end

	// ************************************************************
	// Float model
	// ************************************************************

	function automatic ula_word_t make_float(input logic s, input int e, input int m);
		return {s, e[7:0], m[22:0]};
	endfunction

	// Shift up until bit 22 is set, zero mantissa gets exponent -128
	function automatic ula_word_t normalize_float(input ula_word_t raw);
		logic              s;
		logic signed [7:0] e;
		logic [22:0]       m;
		s = raw[31];
		e = raw[30:23];
		m = raw[22:0];
		if (m == '0)
			return {s, 8'h80, 23'd0};
		while (!m[22]) begin
			m = m << 1;
			e = e - 8'sd1;
		end
		return {s, e, m};
	endfunction

	// Signed mantissas on the larger exponent
	function automatic void align_mantissas(input ula_word_t a, b, output int v1, v2,
		output logic signed [7:0] e);
		logic signed [7:0] e1, e2;
		logic [22:0]       m1, m2;
		int                d;
		e1 = a[30:23];
		e2 = b[30:23];
		m1 = a[22:0];
		m2 = b[22:0];
		d  = int'(e1) - int'(e2);
		if (d >= 0) begin
			m2 = m2 >> d;
			e  = e1;
		end else begin
			m1 = m1 >> (-d);
			e  = e2;
		end
		v1 = a[31] ? -int'(m1) : int'(m1);
		v2 = b[31] ? -int'(m2) : int'(m2);
	endfunction

	function automatic ula_word_t add_floats(input ula_word_t a, b);
		int                v1, v2, sum, mag;
		logic signed [7:0] e;
		align_mantissas(a, b, v1, v2, e);
		sum = v1 + v2;
		mag = (sum < 0) ? -sum : sum;
		return normalize_float({sum < 0, e + 8'sd1, mag[23:1]});  // Lowest bit dropped
	endfunction

	function automatic ula_word_t multiply_floats(input ula_word_t a, b);
		logic [45:0]       p;
		logic [22:0]       m;
		logic signed [7:0] e;
		p = a[22:0] * b[22:0];
		m = p[45:23];
		e = a[30:23] + b[30:23] + 8'sd23;
		if (m == '0)
			return make_float(1'b0, -128, 0);
		return normalize_float({a[31] ^ b[31], e, m});
	endfunction

	function automatic ula_word_t bool_word(input logic f);
		return {31'd0, f};
	endfunction

	// ************************************************************
	// Expected result of one vector
	// ************************************************************

	function automatic ula_word_t expected_result(input logic [5:0] op_code,
		input ula_word_t a, b);
		int                v1, v2;
		logic signed [7:0] e;
		align_mantissas(a, b, v1, v2, e);
		case (op_code)
			NOP:   return b;
			LOD:   return a;
			ADD:   return a + b;
			MLT:   return a * b;
			DIV: begin
				if (b == '0)
					return '0;
				else
					return a / b;    // Signed, toward zero
			end
			MOD: begin
				if (b == '0)
					return '0;
				else
					return a % b;    // Sign of the dividend
			end
			SGN:   return (a[31] == b[31]) ? b : -b;
			NEG:   return -b;
			ABS:   return (b < 0) ? -b : b;
			PST:   return (b < 0) ? '0 : b;
			AND:   return a & b;
			ORR:   return a | b;
			XOR:   return a ^ b;
			INV:   return ~b;
			LAN:   return bool_word((a != '0) && (b != '0));
			LOR:   return bool_word((a != '0) || (b != '0));
			LIN:   return bool_word(b == '0);
			LES:   return bool_word(a < b);
			GRE:   return bool_word(a > b);
			EQU:   return bool_word(a == b);
			SHL:   return a << b;
			SHR:   return a >> b;
			SRS:   return a >>> b;
			F_ADD: return add_floats(a, b);
			F_MLT: return multiply_floats(a, b);
			F_SGN: return {a[31], b[30:0]};
			F_NEG: return {~b[31], b[30:0]};
			F_ABS: return {1'b0, b[30:0]};
			F_PST: return b[31] ? make_float(1'b0, -128, 0) : b;
			F_LES: return bool_word(v1 < v2);
			F_GRE: return bool_word(v1 > v2);
			default: return '0;  // Unused codes
		endcase
	endfunction

	// ************************************************************
	// Drive and check
	// ************************************************************

	task automatic check_value(input string name, input ula_word_t expected, actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			$display("SOME TESTS FAILED");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	// Called 1 ns after an edge, checks 1 ns after the next one
	task automatic apply_vector(input string name, input logic [5:0] op_code,
		input ula_word_t a, b);
		ula_word_t exp_val;
		exp_val = expected_result(op_code, a, b);
		op  = op_code;
		in1 = a;
		in2 = b;
		@(posedge clk);
		#1;
		check_value($sformatf("%s, op %0d", name, op_code), exp_val, out);
	endtask

	task automatic reset_checks();
		arst_n = 1'b0;
		op     = NOP;
		in1    = 32'h0bad_cafe;
		in2    = 32'h1234_5678;  // Would show on out if reset failed
		repeat (RESET_CYCLES) begin
			@(posedge clk);
			#1;
			check_value("reset held", '0, out);
		end
		arst_n = 1'b1;
		apply_vector("unused opcode", 6'd7, 32'sd3, 32'sd9);
		apply_vector("unused opcode", 6'd63, -32'sd1, -32'sd1);
	endtask

	task automatic integer_group();
		apply_vector("divide by zero", DIV, 32'sd1234, 32'sd0);
		apply_vector("modulo by zero", MOD, -32'sd99, 32'sd0);
		foreach (int_ops[i])
			apply_vector("integer directed", int_ops[i], -32'sd7, 32'sd2);
		repeat (RAND_ROUNDS) begin
			foreach (int_ops[i])
				apply_vector("integer random", int_ops[i], $urandom, $urandom);
		end
	endtask

	task automatic logic_group();
		ula_word_t a, b;
		foreach (cond_ops[i]) begin
			apply_vector("conditional zeros", cond_ops[i], 32'sd0, 32'sd0);
			apply_vector("conditional in2 zero", cond_ops[i], 32'sd5, 32'sd0);
			apply_vector("conditional in1 zero", cond_ops[i], 32'sd0, -32'sd5);
		end
		foreach (shift_ops[i]) begin
			foreach (shift_counts[j])
				apply_vector("directed shift", shift_ops[i], 32'h8765_4321, shift_counts[j]);
		end
		apply_vector("equal operands", EQU, -32'sd42, -32'sd42);
		repeat (RAND_ROUNDS) begin
			foreach (logic_ops[i]) begin
				a = $urandom;
				b = $urandom;
				if (logic_ops[i] inside {SHL, SHR, SRS})
					b[31:5] = '0;  // Counts 0 to 31
				apply_vector("logic random", logic_ops[i], a, b);
			end
		end
	endtask

	task automatic float_sign_ops();
		ula_word_t p, n;
		p = make_float(1'b0, 5, 'h4a0000);
		n = make_float(1'b1, -3, 'h612345);
		foreach (sign_ops[i]) begin
			apply_vector("float sign, in2 negative", sign_ops[i], p, n);
			apply_vector("float sign, in2 positive", sign_ops[i], n, p);
		end
	endtask

	task automatic float_arith_ops();
		ula_word_t one, one_half, three, neg_quarter3, zero;
		one          = make_float(1'b0, -22, 'h400000);  // 1.0
		one_half     = make_float(1'b0, -22, 'h600000);  // 1.5
		three        = make_float(1'b0, -21, 'h600000);  // 3.0
		neg_quarter3 = make_float(1'b1, -23, 'h600000);  // -0.75
		zero         = make_float(1'b0, -128, 0);
		apply_vector("float add", F_ADD, one, one_half);
		apply_vector("float add, exponents differ", F_ADD, three, neg_quarter3);
		apply_vector("float add to zero", F_ADD, {1'b1, one[30:0]}, one);
		apply_vector("float multiply", F_MLT, one, one_half);
		apply_vector("float multiply, signs differ", F_MLT, {1'b1, three[30:0]},
			{1'b0, neg_quarter3[30:0]});
		apply_vector("float multiply by zero", F_MLT, zero, one_half);
		apply_vector("float less", F_LES, one_half, three);
		apply_vector("float greater", F_GRE, one_half, three);
		apply_vector("float less, signs differ", F_LES, {1'b1, three[30:0]}, neg_quarter3);
		apply_vector("float greater, signs differ", F_GRE, {1'b1, three[30:0]}, neg_quarter3);
		apply_vector("float less, negative in2", F_LES, {1'b0, neg_quarter3[30:0]},
			{1'b1, one[30:0]});
		apply_vector("float greater, negative in2", F_GRE, {1'b0, neg_quarter3[30:0]},
			{1'b1, one[30:0]});
	endtask

	// New opcode on every edge
	task automatic back_to_back();
		foreach (b2b_ops[i])
			apply_vector("back to back", b2b_ops[i], $urandom, $urandom);
	endtask

	initial begin
		void'($urandom(SEED));
		reset_checks();
		integer_group();
		logic_group();
		float_sign_ops();
		float_arith_ops();
		back_to_back();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
source/ula_pkg.sv
source/ula_unit_if.sv
source/ula_norm.sv
source/ula_int_arith.sv
source/ula_logic.sv
source/ula_float.sv
source/ula_mux.sv
source/ula.sv
verif/ula_asserts.sv
verif/ula_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the ULA testbench with Verilator and runs it
# Exit status is that of the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module ula_tb -o ula_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/ula_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi

exit 0
